//--- tests/store_path_tests.txt
// one store per line, all hex: size addr data id gap bresp
// size 0 byte, 1 half, 2 word; gap is idle cycles before the store
// byte lanes one at a time, then half and word
0 00001000 123456a1 01 3 0
0 00001001 000000b2 02 2 0
0 00001002 ffffffc3 03 1 0
0 00001003 000000d4 04 0 0
1 00002000 abcd1234 05 2 0
1 00002002 00005678 06 0 0
2 00003000 deadbeef 07 4 0
2 00003004 cafef00d 08 0 2
// error responses mixed with okay
0 00004002 0000005a 09 1 3
1 00004006 0000beef 0a 0 0
2 00004008 01020304 0b 2 2
// back-to-back burst against a stalling slave
2 00005000 11111111 10 6 0
2 00005004 22222222 11 0 0
0 00005009 00000033 12 0 0
1 0000500e 00004444 13 0 2
0 00005013 00000055 14 0 0
2 00005018 66666666 15 0 0
1 00005020 00007777 16 0 0
0 00005022 00000088 17 0 3
2 00005028 99999999 18 0 0
2 0000502c aaaaaaaa 19 0 0
// tail after the burst drains
0 00006003 000000bb 20 a 0
1 00006006 0000cccc 21 3 0
2 0000600c dddddddd 3f 1 0

//--- list.f
logic/axi_store_pkg.sv
logic/store_align.sv
logic/write_buffer.sv
logic/axi_write_master.sv
logic/store_path_top.sv
tests/store_path_tb.sv

//--- Bender.yml
package:
  name: store_path

sources:
  - logic/axi_store_pkg.sv
  - logic/store_align.sv
  - logic/write_buffer.sv
  - logic/axi_write_master.sv
  - logic/store_path_top.sv
  - target: test
    files:
      - tests/store_path_tb.sv

//--- tests/store_path_tb.sv
module store_path_tb import axi_store_pkg::*; ();

	localparam int N_STORES   = 24;
	localparam int FIELDS     = 6;
	localparam int MAX_CYCLES = 200 * N_STORES + 100;

	logic               ACLK = 1'b0;
	logic               ARESETn = 1'b0;
	logic               store_en = 1'b0;
	logic [ADDR_W-1:0]  store_addr = '0;
	store_size_e        store_size = SIZE_BYTE;
	logic [DATA_W-1:0]  store_data = '0;
	logic [ID_W-1:0]    store_id = '0;
	logic               store_full;
	logic [ADDR_W-1:0]  AWADDR;
	logic [LEN_W-1:0]   AWLEN;
	logic [SIZE_W-1:0]  AWSIZE;
	logic [BURST_W-1:0] AWBURST;
	logic [ID_W-1:0]    AWID;
	logic               AWVALID;
	logic               AWREADY = 1'b0;
	logic [DATA_W-1:0]  WDATA;
	logic [STRB_W-1:0]  WSTRB;
	logic               WLAST;
	logic [ID_W-1:0]    WID;
	logic               WVALID;
	logic               WREADY = 1'b0;
	logic [RESP_W-1:0]  BRESP = '0;
	logic [ID_W-1:0]    BID = '0;
	logic               BVALID = 1'b0;
	logic               BREADY;
	logic               write_done;
	logic               write_err;
	logic               writing;
	logic [ADDR_W-1:0]  last_write_address;

	// six words per store, see the data file
	logic [31:0] vec [N_STORES * FIELDS];

	// expected requests in issue order
	logic [ADDR_W-1:0] exp_addr [$];
	logic [2:0]        exp_size [$];
	logic [DATA_W-1:0] exp_data [$];
	logic [STRB_W-1:0] exp_strb [$];
	logic [ID_W-1:0]   exp_id   [$];
	logic [RESP_W-1:0] exp_resp [$];

	integer            seed = 79;
	int                rnd;
	int                cycle_count = 0;
	int                done_count = 0;
	int                b_wait = 0;
	logic              store_en_q = 1'b0;
	logic              full_seen = 1'b0;
	logic              resp_owed = 1'b0;
	logic              b_pending = 1'b0;
	logic              done_due = 1'b0;
	logic              err_due = 1'b0;
	logic [RESP_W-1:0] cur_resp = '0;
	logic [ID_W-1:0]   cur_id = '0;

	store_path_top dut_i (.*);

	always #10 ACLK = ~ACLK;

	always @(posedge ACLK) begin
		store_en_q <= store_en;
		cycle_count++;
		if (cycle_count > MAX_CYCLES) begin
			$display("timeout: only %0d of %0d stores completed after %0d cycles",
				done_count, N_STORES, cycle_count);
			$display("TB FAILED");
			$fatal(1);
		end
	end

	task automatic flag_mismatch(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	// one lane for a byte, a lane pair for a half, all for a word
	function automatic logic [STRB_W-1:0] expected_strobe(input logic [2:0] size,
		input logic [1:0] offs);
		case (size)
			3'd0:    return 4'b0001 << offs;
			3'd1:    return offs[1] ? 4'b1100 : 4'b0011;
			default: return 4'b1111;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] replicated_data(input logic [2:0] size,
		input logic [DATA_W-1:0] data);
		case (size)
			3'd0:    return {4{data[7:0]}};
			3'd1:    return {2{data[15:0]}};
			default: return data;
		endcase
	endfunction

	task automatic check_request();
		logic [ADDR_W-1:0] e_addr;
		logic [2:0]        e_size;
		logic [DATA_W-1:0] e_data;
		logic [STRB_W-1:0] e_strb;
		logic [ID_W-1:0]   e_id;
		assert (exp_addr.size() > 0) else abort_run("AXI write request with no store pending");
		e_addr = exp_addr.pop_front();
		e_size = exp_size.pop_front();
		e_data = exp_data.pop_front();
		e_strb = exp_strb.pop_front();
		e_id   = exp_id.pop_front();
		assert (AWADDR == e_addr)
			else flag_mismatch($sformatf("AWADDR %h, expected %h", AWADDR, e_addr));
		assert (AWSIZE == e_size)
			else flag_mismatch($sformatf("AWSIZE %0d, expected %0d", AWSIZE, e_size));
		assert (AWID == e_id && WID == e_id)
			else flag_mismatch($sformatf("AWID %h WID %h, expected %h", AWID, WID, e_id));
		assert (WDATA == e_data)
			else flag_mismatch($sformatf("WDATA %h, expected %h", WDATA, e_data));
		assert (WSTRB == e_strb)
			else flag_mismatch($sformatf("WSTRB %b, expected %b", WSTRB, e_strb));
		assert (AWLEN == '0 && AWBURST == BURST_FIXED && WLAST)
			else flag_mismatch($sformatf("AWLEN %0d AWBURST %0d WLAST %0b", AWLEN, AWBURST, WLAST));
		assert (last_write_address == e_addr)
			else flag_mismatch($sformatf("last_write_address %h, expected %h",
				last_write_address, e_addr));
		cur_resp = exp_resp.pop_front();
		cur_id   = e_id;
	endtask

	////////////////////////////////////////
	// AXI slave and response checks
	////////////////////////////////////////
	always @(posedge ACLK) begin
		if (ARESETn) begin
			if (store_full) begin
				full_seen = 1'b1;
			end
			assert (write_done == done_due)
				else flag_mismatch($sformatf("write_done %0b, expected %0b", write_done, done_due));
			assert (write_err == (done_due && err_due))
				else flag_mismatch($sformatf("write_err %0b, expected %0b", write_err,
					done_due && err_due));
			if (write_done) begin
				done_count++;
			end
			done_due = 1'b0;
			if (resp_owed) begin
				assert (!AWVALID) else abort_run("AWVALID raised before the previous write response");
			end
			// a transaction stays open from AWVALID until its response
			assert (writing == (AWVALID || resp_owed))
				else flag_mismatch($sformatf("writing %0b, expected %0b", writing,
					AWVALID || resp_owed));
			if (AWVALID && AWREADY && WVALID && WREADY) begin
				check_request();
				resp_owed = 1'b1;
				b_pending = 1'b1;
				b_wait    = $random(seed) & 3;
			end
			if (BVALID && BREADY) begin
				BVALID    <= 1'b0;
				resp_owed = 1'b0;
				done_due  = 1'b1;
				err_due   = (cur_resp != RESP_OKAY);
			end else if (b_pending) begin
				if (b_wait == 0) begin
					BVALID    <= 1'b1;
					BRESP     <= cur_resp;
					BID       <= cur_id;
					b_pending = 1'b0;
				end else begin
					b_wait--;
				end
			end
		end
		rnd = $random(seed);
		AWREADY <= rnd[0];
		rnd = $random(seed);
		WREADY <= rnd[0];
	end

	////////////////////////////////////////
	// core side stimulus
	////////////////////////////////////////
	initial begin : driver
		int b;
		int g;
		$readmemh("tests/store_path_tests.txt", vec);
		for (int i = 0; i < N_STORES * FIELDS; i++) begin
			assert (!$isunknown(vec[i])) else abort_run("test file holds fewer stores than expected");
		end
		repeat (5) @(posedge ACLK);
		ARESETn <= 1'b1;
		@(posedge ACLK);
		assert (!AWVALID && !WVALID && !BREADY && !writing && !store_full)
			else flag_mismatch("outputs active right after reset");
		for (int i = 0; i < N_STORES; i++) begin
			b = i * FIELDS;
			for (g = 0; g < vec[b + 4]; g++) begin
				@(posedge ACLK);
				store_en <= 1'b0;
			end
			@(posedge ACLK);
			// store_full is seen one cycle late, so hold off after a store two cycles back
			while (store_full || store_en_q) begin
				store_en <= 1'b0;
				@(posedge ACLK);
			end
			store_en   <= 1'b1;
			store_addr <= vec[b + 1];
			store_size <= store_size_e'(vec[b][2:0]);
			store_data <= vec[b + 2];
			store_id   <= vec[b + 3][ID_W-1:0];
			exp_addr.push_back(vec[b + 1]);
			exp_size.push_back(vec[b][2:0]);
			exp_data.push_back(replicated_data(vec[b][2:0], vec[b + 2]));
			exp_strb.push_back(expected_strobe(vec[b][2:0], vec[b + 1][1:0]));
			exp_id.push_back(vec[b + 3][ID_W-1:0]);
			exp_resp.push_back(vec[b + 5][RESP_W-1:0]);
		end
		@(posedge ACLK);
		store_en <= 1'b0;
		while (done_count < N_STORES) begin
			@(posedge ACLK);
		end
		@(posedge ACLK);
		assert (!AWVALID && !writing) else abort_run("write master still busy after the last response");
		assert (last_write_address == vec[(N_STORES - 1) * FIELDS + 1])
			else flag_mismatch("last_write_address does not hold the final store address");
		assert (full_seen) else abort_run("store_full never rose during the stalled burst");
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- logic/store_path_top.sv
module store_path_top import axi_store_pkg::*; (
	input  logic               ACLK,
	input  logic               ARESETn,
	// core store port
	input  logic               store_en,
	input  logic [ADDR_W-1:0]  store_addr,
	input  store_size_e        store_size,
	input  logic [DATA_W-1:0]  store_data,
	input  logic [ID_W-1:0]    store_id,
	output logic               store_full,
	// AXI3 write address
	output logic [ADDR_W-1:0]  AWADDR,
	output logic [LEN_W-1:0]   AWLEN,
	output logic [SIZE_W-1:0]  AWSIZE,
	output logic [BURST_W-1:0] AWBURST,
	output logic [ID_W-1:0]    AWID,
	output logic               AWVALID,
	input  logic               AWREADY,
	// AXI3 write data
	output logic [DATA_W-1:0]  WDATA,
	output logic [STRB_W-1:0]  WSTRB,
	output logic               WLAST,
	output logic [ID_W-1:0]    WID,
	output logic               WVALID,
	input  logic               WREADY,
	// AXI3 write response
	input  logic [RESP_W-1:0]  BRESP,
	input  logic [ID_W-1:0]    BID,
	input  logic               BVALID,
	output logic               BREADY,
	// status
	output logic               write_done,
	output logic               write_err,
	output logic               writing,
	output logic [ADDR_W-1:0]  last_write_address
);

	// aligner to buffer
	logic              push;
	logic [ADDR_W-1:0] push_addr;
	store_size_e       push_size;
	logic [DATA_W-1:0] push_data;
	logic [STRB_W-1:0] push_strb;
	logic [ID_W-1:0]   push_id;

	// buffer to master
	logic              buf_empty;
	logic              pop;
	logic [ADDR_W-1:0] head_addr;
	store_size_e       head_size;
	logic [DATA_W-1:0] head_data;
	logic [STRB_W-1:0] head_strb;
	logic [ID_W-1:0]   head_id;

	store_align align_i (
		.ACLK        (ACLK),
		.ARESETn     (ARESETn),
		.store_en    (store_en),
		.store_addr  (store_addr),
		.store_size  (store_size),
		.store_data  (store_data),
		.store_id    (store_id),
		.buffer_full (store_full),
		.push        (push),
		.push_addr   (push_addr),
		.push_size   (push_size),
		.push_data   (push_data),
		.push_strb   (push_strb),
		.push_id     (push_id)
	);

	write_buffer buffer_i (
		.ACLK      (ACLK),
		.ARESETn   (ARESETn),
		.push      (push),
		.push_addr (push_addr),
		.push_size (push_size),
		.push_data (push_data),
		.push_strb (push_strb),
		.push_id   (push_id),
		.pop       (pop),
		.empty     (buf_empty),
		.full      (store_full),
		.head_addr (head_addr),
		.head_size (head_size),
		.head_data (head_data),
		.head_strb (head_strb),
		.head_id   (head_id)
	);

	axi_write_master master_i (
		.ACLK               (ACLK),
		.ARESETn            (ARESETn),
		.empty              (buf_empty),
		.head_addr          (head_addr),
		.head_size          (head_size),
		.head_data          (head_data),
		.head_strb          (head_strb),
		.head_id            (head_id),
		.pop                (pop),
		.AWADDR             (AWADDR),
		.AWLEN              (AWLEN),
		.AWSIZE             (AWSIZE),
		.AWBURST            (AWBURST),
		.AWID               (AWID),
		.AWVALID            (AWVALID),
		.AWREADY            (AWREADY),
		.WDATA              (WDATA),
		.WSTRB              (WSTRB),
		.WLAST              (WLAST),
		.WID                (WID),
		.WVALID             (WVALID),
		.WREADY             (WREADY),
		.BRESP              (BRESP),
		.BID                (BID),
		.BVALID             (BVALID),
		.BREADY             (BREADY),
		.write_done         (write_done),
		.write_err          (write_err),
		.writing            (writing),
		.last_write_address (last_write_address)
	);

endmodule

//--- logic/axi_write_master.sv
module axi_write_master import axi_store_pkg::*; (
	input  logic               ACLK,
	input  logic               ARESETn,
	// buffer head
	input  logic               empty,
	input  logic [ADDR_W-1:0]  head_addr,
	input  store_size_e        head_size,
	input  logic [DATA_W-1:0]  head_data,
	input  logic [STRB_W-1:0]  head_strb,
	input  logic [ID_W-1:0]    head_id,
	output logic               pop,
	// write address channel
	output logic [ADDR_W-1:0]  AWADDR,
	output logic [LEN_W-1:0]   AWLEN,
	output logic [SIZE_W-1:0]  AWSIZE,
	output logic [BURST_W-1:0] AWBURST,
	output logic [ID_W-1:0]    AWID,
	output logic               AWVALID,
	input  logic               AWREADY,
	// write data channel
	output logic [DATA_W-1:0]  WDATA,
	output logic [STRB_W-1:0]  WSTRB,
	output logic               WLAST,
	output logic [ID_W-1:0]    WID,
	output logic               WVALID,
	input  logic               WREADY,
	// write response channel
	input  logic [RESP_W-1:0]  BRESP,
	input  logic [ID_W-1:0]    BID,
	input  logic               BVALID,
	output logic               BREADY,
	// status
	output logic               write_done,
	output logic               write_err,
	output logic               writing,
	output logic [ADDR_W-1:0]  last_write_address
);

	wr_state_e       state;
	wr_state_e       next_state;
	logic            req_ok;
	logic            resp_ok;
	logic [ID_W-1:0] pend_id;

	// address and data go out together, both must be taken in one cycle
	assign req_ok  = AWVALID && AWREADY && WVALID && WREADY;
	assign resp_ok = BVALID && BREADY;

	// take the head only when nothing is open
	assign pop = (state == WR_IDLE) && !empty;

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state <= WR_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			WR_IDLE: begin
				if (!empty) begin
					next_state = WR_REQUEST;
				end
			end
			WR_REQUEST: begin
				if (req_ok) begin
					next_state = WR_WAIT_RESP;
				end
			end
			WR_WAIT_RESP: begin
				if (resp_ok) begin
					next_state = WR_IDLE;
				end
			end
			default: next_state = WR_IDLE;
		endcase
	end

	////////////////////////////////////////
	// handshake and status flags
	////////////////////////////////////////
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			AWVALID    <= 1'b0;
			WVALID     <= 1'b0;
			BREADY     <= 1'b0;
			write_done <= 1'b0;
			write_err  <= 1'b0;
		end else begin
			write_done <= resp_ok;
			write_err  <= resp_ok && (BRESP != RESP_OKAY);
			if (pop) begin
				AWVALID <= 1'b1;
				WVALID  <= 1'b1;
			end else if (req_ok) begin
				AWVALID <= 1'b0;
				WVALID  <= 1'b0;
			end
			// ready for the response from the cycle after the request
			if (req_ok) begin
				BREADY <= 1'b1;
			end else if (resp_ok) begin
				BREADY <= 1'b0;
			end
		end
	end

	// request fields, loaded from the head and cleared once taken
	always_ff @(posedge ACLK) begin
		if (pop) begin
			AWADDR             <= head_addr;
			AWSIZE             <= head_size;
			AWID               <= head_id;
			WDATA              <= head_data;
			WSTRB              <= head_strb;
			pend_id            <= head_id;
			last_write_address <= head_addr;
		end else if (req_ok) begin
			AWADDR <= '0;
			AWSIZE <= '0;
			AWID   <= '0;
			WDATA  <= '0;
			WSTRB  <= '0;
		end
	end

	assign AWLEN   = LEN_SINGLE;
	assign AWBURST = BURST_FIXED;
	assign WID     = AWID;
	assign WLAST   = WVALID;
	assign writing = (state != WR_IDLE);

	a_valid_pair: assert property (@(posedge ACLK) disable iff (!ARESETn)
		AWVALID == WVALID);

	// held request keeps its fields until taken
	a_req_stable: assert property (@(posedge ACLK) disable iff (!ARESETn)
		AWVALID && !req_ok |=> AWVALID && WVALID
			&& $stable(AWADDR) && $stable(AWSIZE) && $stable(AWID)
			&& $stable(WDATA) && $stable(WSTRB));

	// slave answers for the transaction still open
	a_bid_match: assert property (@(posedge ACLK) disable iff (!ARESETn)
		resp_ok |-> BID == pend_id);

endmodule

//--- logic/write_buffer.sv
module write_buffer import axi_store_pkg::*; (
	input  logic              ACLK,
	input  logic              ARESETn,
	// from the aligner
	input  logic              push,
	input  logic [ADDR_W-1:0] push_addr,
	input  store_size_e       push_size,
	input  logic [DATA_W-1:0] push_data,
	input  logic [STRB_W-1:0] push_strb,
	input  logic [ID_W-1:0]   push_id,
	// from the write master
	input  logic              pop,
	output logic              empty,
	output logic              full,
	output logic [ADDR_W-1:0] head_addr,
	output store_size_e       head_size,
	output logic [DATA_W-1:0] head_data,
	output logic [STRB_W-1:0] head_strb,
	output logic [ID_W-1:0]   head_id
);

	logic [ADDR_W-1:0] mem_addr [BUF_DEPTH];
	store_size_e       mem_size [BUF_DEPTH];
	logic [DATA_W-1:0] mem_data [BUF_DEPTH];
	logic [STRB_W-1:0] mem_strb [BUF_DEPTH];
	logic [ID_W-1:0]   mem_id   [BUF_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// wrap at the last entry
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge ACLK) begin
		if (push) begin
			mem_addr[wr_ptr] <= push_addr;
			mem_size[wr_ptr] <= push_size;
			mem_data[wr_ptr] <= push_data;
			mem_strb[wr_ptr] <= push_strb;
			mem_id[wr_ptr]   <= push_id;
		end
	end

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign empty = (count == '0);
	// one store may still sit in the aligner, so flag full one entry early
	assign full  = (count >= CNT_W'(BUF_DEPTH - 1));

	assign head_addr = mem_addr[rd_ptr];
	assign head_size = mem_size[rd_ptr];
	assign head_data = mem_data[rd_ptr];
	assign head_strb = mem_strb[rd_ptr];
	assign head_id   = mem_id[rd_ptr];

	a_no_pop_empty: assert property (@(posedge ACLK) disable iff (!ARESETn)
		pop |-> !empty);

	a_no_overflow: assert property (@(posedge ACLK) disable iff (!ARESETn)
		push |-> count < CNT_W'(BUF_DEPTH) || pop);

endmodule

//--- logic/store_align.sv
module store_align import axi_store_pkg::*; (
	input  logic              ACLK,
	input  logic              ARESETn,
	// core store strobe
	input  logic              store_en,
	input  logic [ADDR_W-1:0] store_addr,
	input  store_size_e       store_size,
	input  logic [DATA_W-1:0] store_data,
	input  logic [ID_W-1:0]   store_id,
	input  logic              buffer_full,
	// aligned store to the buffer
	output logic              push,
	output logic [ADDR_W-1:0] push_addr,
	output store_size_e       push_size,
	output logic [DATA_W-1:0] push_data,
	output logic [STRB_W-1:0] push_strb,
	output logic [ID_W-1:0]   push_id
);

	logic [DATA_W-1:0] lane_data;
	logic [STRB_W-1:0] lane_strb;

	// replicate the value over all lanes, strobe picks the live bytes
	always_comb begin
		case (store_size)
			SIZE_BYTE: begin
				lane_data = {(STRB_W){store_data[7:0]}};
				lane_strb = STRB_W'(1) << store_addr[1:0];
			end
			SIZE_HALF: begin
				lane_data = {(STRB_W / 2){store_data[15:0]}};
				lane_strb = STRB_W'(2'b11) << {store_addr[1], 1'b0};
			end
			SIZE_WORD: begin
				lane_data = store_data;
				lane_strb = '1;
			end
			default: begin
				// unknown size writes no byte
				lane_data = store_data;
				lane_strb = '0;
			end
		endcase
	end

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			push <= 1'b0;
		end else begin
			push <= store_en;
		end
	end

	always_ff @(posedge ACLK) begin
		if (store_en) begin
			push_addr <= store_addr;
			push_size <= store_size;
			push_data <= lane_data;
			push_strb <= lane_strb;
			push_id   <= store_id;
		end
	end

	////////////////////////////////////////
	// core side rules
	////////////////////////////////////////
	// full already counts the store held here
	a_no_store_when_full: assert property (@(posedge ACLK) disable iff (!ARESETn)
		store_en |-> !buffer_full);

	a_half_aligned: assert property (@(posedge ACLK) disable iff (!ARESETn)
		store_en && store_size == SIZE_HALF |-> store_addr[0] == 1'b0);

	a_word_aligned: assert property (@(posedge ACLK) disable iff (!ARESETn)
		store_en && store_size == SIZE_WORD |-> store_addr[1:0] == 2'b00);

endmodule

//--- logic/axi_store_pkg.sv
package axi_store_pkg;

	////////////////////////////////////////
	// bus widths
	////////////////////////////////////////
	localparam int DATA_W  = 32;
	localparam int ADDR_W  = 32;
	localparam int ID_W    = 6;
	// one strobe bit per byte lane
	localparam int STRB_W  = DATA_W / 8;

	// write buffer
	localparam int BUF_DEPTH = 4;
	localparam int PTR_W     = $clog2(BUF_DEPTH);
	// count must hold the value BUF_DEPTH itself
	localparam int CNT_W     = $clog2(BUF_DEPTH + 1);

	////////////////////////////////////////
	// AXI3 field widths and codes
	////////////////////////////////////////
	localparam int SIZE_W  = 3;
	localparam int LEN_W   = 4;
	localparam int BURST_W = 2;
	localparam int RESP_W  = 2;

	// single beat
	localparam logic [LEN_W-1:0]   LEN_SINGLE  = '0;
	localparam logic [BURST_W-1:0] BURST_FIXED = 2'b00;
	localparam logic [RESP_W-1:0]  RESP_OKAY   = 2'b00;

	// store size, same encoding as AWSIZE
	typedef enum logic [SIZE_W-1:0] {
		SIZE_BYTE = 3'd0,
		SIZE_HALF = 3'd1,
		SIZE_WORD = 3'd2
	} store_size_e;

	// write master states, one transaction outstanding
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_REQUEST,
		WR_WAIT_RESP
	} wr_state_e;

endpackage
